// ==== rtl/bram_backup_pkg.sv ====
//////////////////////////////
// Widths, sector map and sequencer states shared by the
// backup RAM save and load engine. Files refer to these
// by scoped name.
//////////////////////////////
package bram_backup_pkg;

	//////////////////////////////
	// SD host side
	//////////////////////////////

	// Sector number on the save image
	typedef logic [10:0] lba_t;
	// One SD buffer word, two backup bytes
	typedef logic [15:0] word_t;
	// Word index inside a 512-byte sector
	typedef logic [7:0] word_addr_t;

	//////////////////////////////
	// Byte side
	//////////////////////////////

	typedef logic [7:0] byte_t;
	// Byte index inside a sector
	typedef logic [8:0] byte_addr_t;
	// Console address into the 8 KiB internal RAM
	typedef logic [12:0] bram_addr_t;
	// Cartridge backup address, sector index over byte index
	typedef logic [12:0] cart_addr_t;

	// Sector map of the save image
	localparam int BRAM_SECTORS = 16;
	localparam int CART_SECTORS = 16;
	localparam int CART_FIRST_LBA = 16;

	// Sequencer control states
	typedef enum logic [1:0] {
		IDLE,
		BRAM_XFER,
		CART_SD,
		CART_MOVE
	} seq_state_t;

endpackage

// ==== rtl/backup_store.sv ====
//////////////////////////////
// Internal 8 KiB backup RAM. The console uses the byte port,
// the SD buffer the word port; both see the same bytes with
// the lower byte address in bits 7:0.
//////////////////////////////
`timescale 1ns/100ps

module backup_store (
	input  logic                          clk_sys,
	input  bram_backup_pkg::bram_addr_t   bram_addr,
	input  bram_backup_pkg::byte_t        bram_wdata,
	input  logic                          bram_we,
	output bram_backup_pkg::byte_t        bram_rdata,
	input  logic [3:0]                    sd_sector,
	input  bram_backup_pkg::word_addr_t   sd_buff_addr,
	input  bram_backup_pkg::word_t        sd_wdata,
	input  logic                          sd_we,
	output bram_backup_pkg::word_t        sd_rdata
);

	// Even and odd bytes kept in separate banks
	logic [7:0] mem_lo [0:4095];
	logic [7:0] mem_hi [0:4095];

	logic [11:0] byte_word;
	logic [11:0] sd_word;

	assign byte_word = bram_addr[12:1];
	assign sd_word = {sd_sector, sd_buff_addr};

	always_ff @(posedge clk_sys) begin
		if (sd_we)
			mem_lo[sd_word] <= sd_wdata[7:0];
		if (bram_we && !bram_addr[0])
			mem_lo[byte_word] <= bram_wdata;
	end

	always_ff @(posedge clk_sys) begin
		if (sd_we)
			mem_hi[sd_word] <= sd_wdata[15:8];
		if (bram_we && bram_addr[0])
			mem_hi[byte_word] <= bram_wdata;
	end

	// Registered reads on both ports
	always_ff @(posedge clk_sys) begin
		bram_rdata <= bram_addr[0] ? mem_hi[byte_word] : mem_lo[byte_word];
		sd_rdata <= {mem_hi[sd_word], mem_lo[sd_word]};
	end

	// Console and SD host never write the same word at once
	a_no_write_clash: assert property (@(posedge clk_sys)
		!(bram_we && sd_we && byte_word == sd_word));

endmodule

// ==== rtl/sector_stage.sv ====
//////////////////////////////
// One-sector staging buffer for the cartridge area.
// Word port faces the SD host, byte port the byte mover.
//////////////////////////////
`timescale 1ns/100ps

module sector_stage (
	input  logic                          clk_sys,
	input  bram_backup_pkg::word_addr_t   sd_buff_addr,
	input  bram_backup_pkg::word_t        sd_wdata,
	input  logic                          sd_we,
	output bram_backup_pkg::word_t        sd_rdata,
	input  bram_backup_pkg::byte_addr_t   byte_addr,
	input  bram_backup_pkg::byte_t        byte_wdata,
	input  logic                          byte_we,
	output bram_backup_pkg::byte_t        byte_rdata
);

	logic [7:0] stage_lo [0:255];
	logic [7:0] stage_hi [0:255];

	bram_backup_pkg::word_addr_t byte_word;

	assign byte_word = byte_addr[8:1];

	always_ff @(posedge clk_sys) begin
		if (sd_we)
			stage_lo[sd_buff_addr] <= sd_wdata[7:0];
		if (byte_we && !byte_addr[0])
			stage_lo[byte_word] <= byte_wdata;
	end

	always_ff @(posedge clk_sys) begin
		if (sd_we)
			stage_hi[sd_buff_addr] <= sd_wdata[15:8];
		if (byte_we && byte_addr[0])
			stage_hi[byte_word] <= byte_wdata;
	end

	// One cycle read latency, as in the internal RAM
	always_ff @(posedge clk_sys) begin
		byte_rdata <= byte_addr[0] ? stage_hi[byte_word] : stage_lo[byte_word];
		sd_rdata <= {stage_hi[sd_buff_addr], stage_lo[sd_buff_addr]};
	end

endmodule

// ==== rtl/cart_byte_mover.sv ====
//////////////////////////////
// Moves the 512 bytes of one cartridge sector between the
// staging buffer and cartridge memory. move_dir high sends
// buffer to memory, low fetches memory into the buffer.
//////////////////////////////
`timescale 1ns/100ps

module cart_byte_mover (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          move_start,
	input  logic                          move_dir,
	input  logic [3:0]                    move_sector,
	output logic                          move_done,
	output bram_backup_pkg::byte_addr_t   stage_addr,
	output bram_backup_pkg::byte_t        stage_wdata,
	output logic                          stage_we,
	input  bram_backup_pkg::byte_t        stage_rdata,
	output bram_backup_pkg::cart_addr_t   cart_addr,
	output bram_backup_pkg::byte_t        cart_wdata,
	output logic                          cart_rd,
	output logic                          cart_wr,
	input  bram_backup_pkg::byte_t        cart_rdata,
	input  logic                          cart_busy
);

	bram_backup_pkg::byte_addr_t byte_cnt;
	logic in_flight;
	logic busy_d;
	logic busy_rise;
	logic busy_fall;

	assign busy_rise = cart_busy & ~busy_d;
	assign busy_fall = busy_d & ~cart_busy;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			byte_cnt <= '0;
			in_flight <= 1'b0;
			move_done <= 1'b0;
			busy_d <= 1'b0;
			cart_rd <= 1'b0;
			cart_wr <= 1'b0;
		end else begin
			busy_d <= cart_busy;
			// Memory took the request
			if (busy_rise) begin
				cart_rd <= 1'b0;
				cart_wr <= 1'b0;
			end
			if (!move_start) begin
				byte_cnt <= '0;
				in_flight <= 1'b0;
				move_done <= 1'b0;
			end else if (!move_done) begin
				if (!in_flight) begin
					in_flight <= 1'b1;
					if (move_dir)
						cart_wr <= 1'b1;
					else
						cart_rd <= 1'b1;
				end else if (busy_fall) begin
					in_flight <= 1'b0;
					if (&byte_cnt)
						move_done <= 1'b1;
					else
						byte_cnt <= byte_cnt + 1'b1;
				end
			end
		end
	end

	// Stage read data settles one cycle before each write request
	assign stage_addr = byte_cnt;
	assign cart_wdata = stage_rdata;
	assign cart_addr = {move_sector, byte_cnt};

	// Fetched byte lands in the buffer at the end of busy
	assign stage_wdata = cart_rdata;
	assign stage_we = move_start & ~move_dir & in_flight & busy_fall;

	a_one_request: assert property (@(posedge clk_sys) disable iff (reset)
		!(cart_rd && cart_wr));

endmodule

// ==== rtl/save_tracker.sv ====
//////////////////////////////
// Tracks the save image mount, unsaved changes and the
// edges that start a save or a load. A download end pulses
// both starts, which the sequencer runs as a plain load.
//////////////////////////////
`timescale 1ns/100ps

module save_tracker (
	input  logic clk_sys,
	input  logic reset,
	input  logic save_download,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic bram_we,
	input  logic cart_write,
	input  logic cart_en,
	input  logic bk_load,
	input  logic bk_save,
	input  logic autosave,
	input  logic osd_status,
	input  logic bk_busy,
	output logic bk_ena,
	output logic sav_pending,
	output logic start_load,
	output logic start_save
);

	logic old_download;
	logic old_change;
	logic old_load;
	logic old_save;
	logic old_osd;
	logic bk_change;
	logic download_end;
	logic allow;

	// Cartridge writes only count with the cartridge area enabled
	assign bk_change = bram_we | (cart_write & cart_en);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			old_change <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_osd <= 1'b0;
			bk_ena <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			old_download <= save_download;
			old_change <= bk_change;
			old_load <= bk_load;
			old_save <= bk_save;
			old_osd <= osd_status;
			if (~old_download & save_download)
				bk_ena <= 1'b0;
			// Image gets mounted before the download finishes
			if (save_download & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;
			if (~old_change & bk_change)
				sav_pending <= 1'b1;
			else if (bk_busy)
				sav_pending <= 1'b0;
		end
	end

	assign download_end = old_download & ~save_download;
	assign allow = bk_ena & ~bk_busy;

	assign start_load = allow & ((~old_load & bk_load) | download_end);
	assign start_save = allow & ((~old_save & bk_save) | download_end |
		(~old_osd & osd_status & autosave & sav_pending));

endmodule

// ==== rtl/backup_sequencer.sv ====
//////////////////////////////
// Save/load control. Internal RAM goes straight through the
// SD buffer, cartridge sectors go through the staging buffer
// and the byte mover one sector at a time.
//////////////////////////////
`timescale 1ns/100ps

module backup_sequencer (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    start_load,
	input  logic                    start_save,
	input  logic                    cart_en,
	output bram_backup_pkg::lba_t   sd_lba,
	output logic                    sd_rd,
	output logic                    sd_wr,
	input  logic                    sd_ack,
	output logic                    move_start,
	output logic                    move_dir,
	output logic [3:0]              move_sector,
	input  logic                    move_done,
	output logic                    bk_busy,
	output logic                    bk_reload
);

	localparam bram_backup_pkg::lba_t BRAM_LAST =
		bram_backup_pkg::lba_t'(bram_backup_pkg::BRAM_SECTORS - 1);
	localparam bram_backup_pkg::lba_t CART_LAST = bram_backup_pkg::lba_t'(
		bram_backup_pkg::CART_FIRST_LBA + bram_backup_pkg::CART_SECTORS - 1);

	bram_backup_pkg::seq_state_t state;
	logic loading;
	logic old_ack;
	logic ack_rise;
	logic ack_fall;

	assign ack_rise = ~old_ack & sd_ack;
	// Sector finished on the SD side
	assign ack_fall = old_ack & ~sd_ack;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= bram_backup_pkg::IDLE;
			sd_lba <= '0;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
			loading <= 1'b0;
			bk_reload <= 1'b0;
			old_ack <= 1'b0;
			move_start <= 1'b0;
			move_dir <= 1'b0;
		end else begin
			old_ack <= sd_ack;
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				bram_backup_pkg::IDLE: begin
					sd_lba <= '0;
					move_start <= 1'b0;
					bk_reload <= 1'b0;
					if (start_load | start_save) begin
						state <= bram_backup_pkg::BRAM_XFER;
						loading <= start_load;
						// Both starts together come from a finished download
						bk_reload <= start_load & ~start_save;
						sd_rd <= start_load;
						sd_wr <= ~start_load;
					end
				end

				bram_backup_pkg::BRAM_XFER: begin
					if (ack_fall) begin
						sd_lba <= sd_lba + 1'b1;
						if (sd_lba != BRAM_LAST) begin
							sd_rd <= loading;
							sd_wr <= ~loading;
						end else if (!cart_en) begin
							state <= bram_backup_pkg::IDLE;
						end else if (loading) begin
							state <= bram_backup_pkg::CART_SD;
							sd_rd <= 1'b1;
						end else begin
							// Fetch the first cartridge sector before writing it
							state <= bram_backup_pkg::CART_MOVE;
							move_start <= 1'b1;
							move_dir <= 1'b0;
						end
					end
				end

				bram_backup_pkg::CART_SD: begin
					if (ack_fall) begin
						if (loading) begin
							state <= bram_backup_pkg::CART_MOVE;
							move_start <= 1'b1;
							move_dir <= 1'b1;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							if (sd_lba == CART_LAST) begin
								state <= bram_backup_pkg::IDLE;
							end else begin
								state <= bram_backup_pkg::CART_MOVE;
								move_start <= 1'b1;
								move_dir <= 1'b0;
							end
						end
					end
				end

				bram_backup_pkg::CART_MOVE: begin
					if (move_done) begin
						move_start <= 1'b0;
						if (!loading) begin
							state <= bram_backup_pkg::CART_SD;
							sd_wr <= 1'b1;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							if (sd_lba == CART_LAST) begin
								state <= bram_backup_pkg::IDLE;
							end else begin
								state <= bram_backup_pkg::CART_SD;
								sd_rd <= 1'b1;
							end
						end
					end
				end

				default: state <= bram_backup_pkg::IDLE;
			endcase
		end
	end

	assign bk_busy = (state != bram_backup_pkg::IDLE);
	// Cartridge sector index relative to the first cartridge LBA
	assign move_sector = 4'(sd_lba - bram_backup_pkg::lba_t'(bram_backup_pkg::CART_FIRST_LBA));

	a_one_sd_request: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr));

endmodule

// ==== rtl/bram_backup_top.sv ====
//////////////////////////////
// Backup RAM save/load engine. Connects the tracker and the
// sequencer to the internal RAM, the staging buffer and the
// cartridge mover, and steers SD buffer traffic by sector.
//////////////////////////////
`timescale 1ns/100ps

module bram_backup_top (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  bram_backup_pkg::bram_addr_t   bram_addr,
	input  bram_backup_pkg::byte_t        bram_wdata,
	input  logic                          bram_we,
	output bram_backup_pkg::byte_t        bram_rdata,
	input  logic                          cart_write,
	input  logic                          bk_load,
	input  logic                          bk_save,
	input  logic                          autosave,
	input  logic                          osd_status,
	input  logic                          cart_en,
	input  logic                          save_download,
	input  logic                          img_mounted,
	input  logic                          img_readonly,
	output bram_backup_pkg::lba_t         sd_lba,
	output logic                          sd_rd,
	output logic                          sd_wr,
	input  logic                          sd_ack,
	input  bram_backup_pkg::word_addr_t   sd_buff_addr,
	input  bram_backup_pkg::word_t        sd_buff_dout,
	input  logic                          sd_buff_wr,
	output bram_backup_pkg::word_t        sd_buff_din,
	output bram_backup_pkg::cart_addr_t   cart_addr,
	output bram_backup_pkg::byte_t        cart_wdata,
	output logic                          cart_rd,
	output logic                          cart_wr,
	input  bram_backup_pkg::byte_t        cart_rdata,
	input  logic                          cart_busy,
	output logic                          bk_busy,
	output logic                          bk_reload,
	output logic                          sav_pending
);

	logic start_load;
	logic start_save;
	logic move_start;
	logic move_dir;
	logic [3:0] move_sector;
	logic move_done;
	logic sel_cart;
	bram_backup_pkg::word_t store_sd_rdata;
	bram_backup_pkg::word_t stage_sd_rdata;
	bram_backup_pkg::byte_addr_t stage_addr;
	bram_backup_pkg::byte_t stage_wdata;
	bram_backup_pkg::byte_t stage_rdata;
	logic stage_we;

	//////////////////////////////
	// SD buffer routing
	//////////////////////////////
	assign sel_cart = (sd_lba >= bram_backup_pkg::lba_t'(bram_backup_pkg::CART_FIRST_LBA));
	assign sd_buff_din = sel_cart ? stage_sd_rdata : store_sd_rdata;

	save_tracker u_tracker (
		.clk_sys(clk_sys), .reset(reset),
		.save_download(save_download), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .bram_we(bram_we), .cart_write(cart_write),
		.cart_en(cart_en), .bk_load(bk_load), .bk_save(bk_save),
		.autosave(autosave), .osd_status(osd_status), .bk_busy(bk_busy),
		.bk_ena(), .sav_pending(sav_pending),
		.start_load(start_load), .start_save(start_save)
	);

	backup_sequencer u_sequencer (
		.clk_sys(clk_sys), .reset(reset),
		.start_load(start_load), .start_save(start_save), .cart_en(cart_en),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_ack(sd_ack),
		.move_start(move_start), .move_dir(move_dir),
		.move_sector(move_sector), .move_done(move_done),
		.bk_busy(bk_busy), .bk_reload(bk_reload)
	);

	backup_store u_store (
		.clk_sys(clk_sys),
		.bram_addr(bram_addr), .bram_wdata(bram_wdata),
		.bram_we(bram_we), .bram_rdata(bram_rdata),
		.sd_sector(sd_lba[3:0]), .sd_buff_addr(sd_buff_addr),
		.sd_wdata(sd_buff_dout), .sd_we(sd_buff_wr & sd_ack & ~sel_cart),
		.sd_rdata(store_sd_rdata)
	);

	sector_stage u_stage (
		.clk_sys(clk_sys),
		.sd_buff_addr(sd_buff_addr), .sd_wdata(sd_buff_dout),
		.sd_we(sd_buff_wr & sd_ack & sel_cart), .sd_rdata(stage_sd_rdata),
		.byte_addr(stage_addr), .byte_wdata(stage_wdata),
		.byte_we(stage_we), .byte_rdata(stage_rdata)
	);

	cart_byte_mover u_mover (
		.clk_sys(clk_sys), .reset(reset),
		.move_start(move_start), .move_dir(move_dir),
		.move_sector(move_sector), .move_done(move_done),
		.stage_addr(stage_addr), .stage_wdata(stage_wdata),
		.stage_we(stage_we), .stage_rdata(stage_rdata),
		.cart_addr(cart_addr), .cart_wdata(cart_wdata),
		.cart_rd(cart_rd), .cart_wr(cart_wr),
		.cart_rdata(cart_rdata), .cart_busy(cart_busy)
	);

endmodule

// ==== tests/bram_backup_tb.sv ====
//////////////////////////////
// Testbench for the backup RAM save/load engine. Models the
// SD host and cartridge memory, applies a table of operations
// and checks the save image, both RAMs and the status flags.
//////////////////////////////
`timescale 1ns/100ps

module bram_backup_tb;

	typedef enum int {
		OP_SAVE, OP_LOAD, OP_MOUNT_RW, OP_MOUNT_RO,
		OP_WRITES, OP_AUTOSAVE, OP_CART_WRITE
	} op_t;

	localparam logic [31:0] SEED = 32'h438ae785;
	localparam int SECTOR_BYTES = 512;
	localparam int BRAM_BYTES = bram_backup_pkg::BRAM_SECTORS * SECTOR_BYTES;
	localparam int CART_BYTES = bram_backup_pkg::CART_SECTORS * SECTOR_BYTES;
	localparam int CART_BASE = bram_backup_pkg::CART_FIRST_LBA * SECTOR_BYTES;
	localparam int DISK_SECTORS = bram_backup_pkg::CART_FIRST_LBA + bram_backup_pkg::CART_SECTORS;
	localparam int DISK_WORDS = DISK_SECTORS * SECTOR_BYTES / 2;
	localparam int SD_MAX_DELAY = 8;
	localparam int MEM_MAX_BUSY = 3;
	// Worst case of one operation, its console read-back and some slack
	localparam int STEP_CYCLES =
		DISK_SECTORS * (SD_MAX_DELAY + SECTOR_BYTES / 2 + 8) +
		CART_BYTES * (MEM_MAX_BUSY + 4) + BRAM_BYTES + 1000;

	logic clk_sys = 1'b0;
	logic reset;
	bram_backup_pkg::bram_addr_t bram_addr;
	bram_backup_pkg::byte_t bram_wdata;
	logic bram_we;
	bram_backup_pkg::byte_t bram_rdata;
	logic cart_write;
	logic bk_load;
	logic bk_save;
	logic autosave;
	logic osd_status;
	logic cart_en;
	logic save_download;
	logic img_mounted;
	logic img_readonly;
	bram_backup_pkg::lba_t sd_lba;
	logic sd_rd;
	logic sd_wr;
	logic sd_ack;
	bram_backup_pkg::word_addr_t sd_buff_addr;
	bram_backup_pkg::word_t sd_buff_dout;
	logic sd_buff_wr;
	bram_backup_pkg::word_t sd_buff_din;
	bram_backup_pkg::cart_addr_t cart_addr;
	bram_backup_pkg::byte_t cart_wdata;
	logic cart_rd;
	logic cart_wr;
	bram_backup_pkg::byte_t cart_rdata;
	logic cart_busy;
	logic bk_busy;
	logic bk_reload;
	logic sav_pending;

	// Save image, cartridge memory and the expected console RAM
	bram_backup_pkg::word_t disk [0:DISK_WORDS-1];
	bram_backup_pkg::byte_t cart_mem [0:CART_BYTES-1];
	bram_backup_pkg::byte_t ref_ram [0:BRAM_BYTES-1];
	bram_backup_pkg::byte_t cart_snap [0:CART_BYTES-1];

	// Operation table
	op_t op_tab [$];
	logic cen_tab [$];
	logic busy_tab [$];
	logic reload_tab [$];
	logic pending_tab [$];

	int cycle_count = 0;
	int timeout_limit;

	bram_backup_top uut (.*);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > timeout_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_limit);
			stop_with_failure();
		end
	end

	task automatic stop_with_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("Error: time %0d ns, %s expected %b, got %b", $time, name, exp, got);
			stop_with_failure();
		end
	endtask

	task automatic compare_byte(input string name, input int idx,
			input bram_backup_pkg::byte_t got, input bram_backup_pkg::byte_t exp);
		assert (got === exp) else begin
			$display("Error: time %0d ns, %s[%0d] expected %h, got %h",
				$time, name, idx, exp, got);
			stop_with_failure();
		end
	endtask

	// Image byte index is lba * 512 + byte; lower address in bits 7:0
	function automatic bram_backup_pkg::byte_t disk_byte(input int idx);
		if (idx % 2 == 0)
			return disk[idx / 2][7:0];
		else
			return disk[idx / 2][15:8];
	endfunction

	task automatic add_step(input op_t op, input logic cen, input logic exp_busy,
			input logic exp_reload, input logic exp_pending);
		op_tab.push_back(op);
		cen_tab.push_back(cen);
		busy_tab.push_back(exp_busy);
		reload_tab.push_back(exp_reload);
		pending_tab.push_back(exp_pending);
	endtask

	task automatic write_console(input int count);
		int addr;
		bram_backup_pkg::byte_t data;
		repeat (count) begin
			addr = $urandom_range(BRAM_BYTES - 1, 0);
			data = bram_backup_pkg::byte_t'($urandom);
			bram_addr = bram_backup_pkg::bram_addr_t'(addr);
			bram_wdata = data;
			bram_we = 1'b1;
			ref_ram[addr] = data;
			next_cycle();
		end
		bram_we = 1'b0;
	endtask

	// Console side cartridge writes, each with its cart_write pulse
	task automatic touch_cart(input int count);
		int idx;
		repeat (count) begin
			idx = $urandom_range(CART_BYTES - 1, 0);
			cart_mem[idx] = bram_backup_pkg::byte_t'($urandom);
			cart_write = 1'b1;
			next_cycle();
			cart_write = 1'b0;
			next_cycle();
		end
	endtask

	task automatic verify_save(input logic cen);
		for (int i = 0; i < BRAM_BYTES; i++)
			compare_byte("sd_disk", i, disk_byte(i), ref_ram[i]);
		for (int i = 0; i < CART_BYTES; i++) begin
			if (cen)
				compare_byte("sd_disk", CART_BASE + i, disk_byte(CART_BASE + i), cart_mem[i]);
			else
				compare_byte("sd_disk", CART_BASE + i, disk_byte(CART_BASE + i), cart_snap[i]);
		end
	endtask

	task automatic verify_load(input logic cen);
		for (int i = 0; i < BRAM_BYTES; i++) begin
			bram_addr = bram_backup_pkg::bram_addr_t'(i);
			next_cycle();
			compare_byte("bram_rdata", i, bram_rdata, disk_byte(i));
			ref_ram[i] = disk_byte(i);
		end
		if (cen) begin
			for (int i = 0; i < CART_BYTES; i++)
				compare_byte("cart_mem", i, cart_mem[i], disk_byte(CART_BASE + i));
		end
	endtask

	task automatic run_step(input op_t op, input logic cen, input logic exp_busy,
			input logic exp_reload, input logic exp_pending);
		for (int i = 0; i < CART_BYTES; i++)
			cart_snap[i] = disk_byte(CART_BASE + i);
		cart_en = cen;
		case (op)
			OP_SAVE: bk_save = 1'b1;
			OP_LOAD: begin
				// Fresh image so the load has new data to show
				for (int i = 0; i < DISK_WORDS; i++)
					disk[i] = bram_backup_pkg::word_t'($urandom);
				bk_load = 1'b1;
			end
			OP_AUTOSAVE: begin
				autosave = 1'b1;
				osd_status = 1'b1;
			end
			OP_WRITES: begin
				write_console(64);
				// Console writes alone raise the pending flag
				expect_bit("sav_pending", sav_pending, 1'b1);
				touch_cart(16);
			end
			OP_CART_WRITE: touch_cart(16);
			default: begin
				// Save download with the image mount in the middle
				save_download = 1'b1;
				next_cycle();
				img_mounted = 1'b1;
				img_readonly = (op == OP_MOUNT_RO);
				next_cycle();
				img_mounted = 1'b0;
				next_cycle();
				save_download = 1'b0;
			end
		endcase
		next_cycle();
		expect_bit("bk_busy", bk_busy, exp_busy);
		if (exp_busy) begin
			while (bk_busy) begin
				expect_bit("bk_reload", bk_reload, exp_reload);
				next_cycle();
			end
		end else begin
			repeat (4) begin
				next_cycle();
				expect_bit("bk_busy", bk_busy, 1'b0);
			end
		end
		bk_save = 1'b0;
		bk_load = 1'b0;
		osd_status = 1'b0;
		next_cycle();
		expect_bit("sav_pending", sav_pending, exp_pending);
		if (exp_busy && (op == OP_SAVE || op == OP_AUTOSAVE))
			verify_save(cen);
		if (exp_busy && (op == OP_LOAD || op == OP_MOUNT_RW))
			verify_load(cen);
	endtask

	//////////////////////////////
	// SD host model
	//////////////////////////////
	initial begin : sd_host
		int base;
		int delay;
		logic is_write;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		forever begin
			next_cycle();
			if (!reset && (sd_rd || sd_wr)) begin
				assert (int'(sd_lba) < DISK_SECTORS) else begin
					$display("SD request for sector %0d lies outside the save image", sd_lba);
					stop_with_failure();
				end
				is_write = sd_wr;
				base = int'(sd_lba) * (SECTOR_BYTES / 2);
				delay = $urandom_range(SD_MAX_DELAY, 0);
				repeat (delay)
					next_cycle();
				sd_ack = 1'b1;
				// Host read data trails the word address by one cycle
				for (int i = 0; i <= SECTOR_BYTES / 2; i++) begin
					if (is_write && i > 0)
						disk[base + i - 1] = sd_buff_din;
					if (i < SECTOR_BYTES / 2) begin
						sd_buff_addr = bram_backup_pkg::word_addr_t'(i);
						sd_buff_dout = disk[base + i];
						sd_buff_wr = ~is_write;
						next_cycle();
					end
				end
				sd_buff_wr = 1'b0;
				sd_ack = 1'b0;
			end
		end
	end

	//////////////////////////////
	// Cartridge memory model
	//////////////////////////////
	initial begin : cart_memory
		int addr;
		int hold;
		logic is_write;
		bram_backup_pkg::byte_t wdata;
		cart_rdata = '0;
		cart_busy = 1'b0;
		forever begin
			next_cycle();
			if (!reset && (cart_rd || cart_wr)) begin
				addr = int'(cart_addr);
				is_write = cart_wr;
				wdata = cart_wdata;
				cart_busy = 1'b1;
				hold = $urandom_range(MEM_MAX_BUSY, 1);
				repeat (hold)
					next_cycle();
				if (is_write)
					cart_mem[addr] = wdata;
				else
					cart_rdata = cart_mem[addr];
				cart_busy = 1'b0;
			end
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin : run_table
		reset = 1'b1;
		bram_addr = '0;
		bram_wdata = '0;
		bram_we = 1'b0;
		cart_write = 1'b0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		autosave = 1'b0;
		osd_status = 1'b0;
		cart_en = 1'b0;
		save_download = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		void'($urandom(SEED));
		for (int i = 0; i < DISK_WORDS; i++)
			disk[i] = bram_backup_pkg::word_t'($urandom);
		for (int i = 0; i < CART_BYTES; i++)
			cart_mem[i] = bram_backup_pkg::byte_t'($urandom);

		// Op, cart_en, busy, reload, pending
		add_step(OP_SAVE, 1'b1, 1'b0, 1'b0, 1'b0);
		add_step(OP_MOUNT_RO, 1'b1, 1'b0, 1'b0, 1'b0);
		add_step(OP_LOAD, 1'b1, 1'b0, 1'b0, 1'b0);
		add_step(OP_MOUNT_RW, 1'b1, 1'b1, 1'b0, 1'b0);
		add_step(OP_WRITES, 1'b1, 1'b0, 1'b0, 1'b1);
		add_step(OP_SAVE, 1'b1, 1'b1, 1'b0, 1'b0);
		add_step(OP_LOAD, 1'b1, 1'b1, 1'b1, 1'b0);
		add_step(OP_AUTOSAVE, 1'b1, 1'b0, 1'b0, 1'b0);
		add_step(OP_WRITES, 1'b1, 1'b0, 1'b0, 1'b1);
		add_step(OP_AUTOSAVE, 1'b1, 1'b1, 1'b0, 1'b0);
		add_step(OP_CART_WRITE, 1'b0, 1'b0, 1'b0, 1'b0);
		add_step(OP_SAVE, 1'b0, 1'b1, 1'b0, 1'b0);
		add_step(OP_MOUNT_RO, 1'b1, 1'b0, 1'b0, 1'b0);
		add_step(OP_SAVE, 1'b1, 1'b0, 1'b0, 1'b0);
		timeout_limit = op_tab.size() * STEP_CYCLES + 100;

		repeat (5)
			@(posedge clk_sys);
		#2;
		reset = 1'b0;
		next_cycle();
		expect_bit("bk_busy", bk_busy, 1'b0);
		expect_bit("sav_pending", sav_pending, 1'b0);

		for (int s = 0; s < op_tab.size(); s++)
			run_step(op_tab[s], cen_tab[s], busy_tab[s], reload_tab[s], pending_tab[s]);

		$display("Test passed");
		$finish;
	end

endmodule

// ==== bram_backup.f ====
rtl/bram_backup_pkg.sv
rtl/backup_store.sv
rtl/sector_stage.sv
rtl/cart_byte_mover.sv
rtl/save_tracker.sv
rtl/backup_sequencer.sv
rtl/bram_backup_top.sv
tests/bram_backup_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the backup RAM engine testbench with Verilator and runs it.
# The exit status is the simulator's: nonzero when the run fails.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=bram_backup_sim

verilator --binary --timing --assert -Wno-fatal \
	--top-module bram_backup_tb \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN" \
	-f bram_backup.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi
exit 0
